// ==== vlog.f ====
source/salu_pkg.sv
source/salu_operand_if.sv
source/salu_decoder.sv
source/salu_arith.sv
source/salu_logic.sv
source/salu_compare.sv
source/scalar_alu.sv
testbench/scalar_alu_assertions.sv
testbench/tb_scalar_alu.sv

// ==== Makefile ====
# Verilator build and run of the scalar ALU testbench

.PHONY: all run lint clean

all: run

obj_dir/sim: vlog.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_scalar_alu -f vlog.f -Mdir obj_dir -o sim

run: obj_dir/sim
	./obj_dir/sim | tee sim.log
	grep -qx "Everything OK" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module tb_scalar_alu -f vlog.f

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_scalar_alu.sv ====
module tb_scalar_alu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 5;
    localparam int n_rand       = 8;
    // arith, logic, unary, compare and illegal vectors
    localparam int num_vectors  = 9 * (25 + n_rand) + 10 * (n_rand + 1) + 12 + 12 * 6 + 15;

    logic               clk;
    logic               rst;
    salu_pkg::dword_t   s1;
    salu_pkg::dword_t   s2;
    salu_pkg::dword_t   exec;
    logic               scc;
    salu_pkg::control_t control;
    salu_pkg::dword_t   out;
    logic               scc_val;
    logic               scc_we;
    logic               illegal;

    integer seed;

    // expected response of the op now in the output register
    logic               pending;
    salu_pkg::control_t exp_ctl;
    salu_pkg::dword_t   exp_out;
    logic               exp_scc;
    logic               exp_we;
    logic               exp_ill;

    scalar_alu scalar_alu_i (
        .clk     (clk),
        .rst     (rst),
        .s1      (s1),
        .s2      (s2),
        .exec    (exec),
        .scc     (scc),
        .control (control),
        .out     (out),
        .scc_val (scc_val),
        .scc_we  (scc_we),
        .illegal (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((num_vectors + reset_cycles + 20) * clk_period);
        $display("Watchdog expired before all tests completed");
        $display("Something failed");
        $fatal(1, "timeout");
    end

    task automatic check(input string what, input salu_pkg::dword_t got,
                         input salu_pkg::dword_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic salu_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic salu_pkg::dword_t rand_dword();
        return {rand_word(), rand_word()};
    endfunction

    // signed order is unsigned order with the sign bits flipped
    function automatic logic lt_signed(input salu_pkg::word_t a, input salu_pkg::word_t b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    // reference model of one instruction
    function automatic void model(input salu_pkg::control_t c, input salu_pkg::dword_t x,
            input salu_pkg::dword_t y, input salu_pkg::dword_t e, input logic si,
            output salu_pkg::dword_t r, output logic f, output logic we, output logic bad);
        salu_pkg::word_t a;
        salu_pkg::word_t b;
        logic [63:0]     ext;
        int              i;
        a    = x[31:0];
        b    = y[31:0];
        r    = '0;
        f    = 1'b0;
        we   = 1'b1;
        bad  = 1'b0;
        ext  = {{32{a[31]}}, a} >> b[4:0];
        case (c)
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_ADD_U32}: begin
                r[31:0] = a + b;
                // the wrapped sum falls below a exactly on a carry out
                f       = r[31:0] < a;
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_SUB_U32}: begin
                r[31:0] = a - b;
                f       = a < b;
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_ADD_I32},
            {salu_pkg::FMT_SOPK, salu_pkg::OPC_ADDK_I32}: begin
                r[31:0] = a + b;
                f       = (a[31] == b[31]) && (r[31] != a[31]);
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_SUB_I32}: begin
                r[31:0] = a - b;
                f       = (a[31] != b[31]) && (r[31] != a[31]);
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_MIN_U32}: begin
                f       = a < b;
                r[31:0] = f ? a : b;
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_MAX_U32}: begin
                f       = a > b;
                r[31:0] = f ? a : b;
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_MAX_I32}: begin
                f       = lt_signed(b, a);
                r[31:0] = f ? a : b;
            end
            {salu_pkg::FMT_SOPK, salu_pkg::OPC_MOVK_I32}: begin
                r[31:0] = b;
                we      = 1'b0;
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_CSELECT_B32}: begin
                r[31:0] = si ? a : b;
                we      = 1'b0;
            end
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_AND_B32}:  r[31:0] = a & b;
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_OR_B32}:   r[31:0] = a | b;
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_AND_B64}:  r = x & y;
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_OR_B64}:   r = x | y;
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_ANDN2_B64}: r = x & ~y;
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_LSHL_B32}: r[31:0] = a << b[4:0];
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_LSHR_B32}: r[31:0] = a >> b[4:0];
            {salu_pkg::FMT_SOP2, salu_pkg::OPC_ASHR_I32}: r[31:0] = ext[31:0];
            {salu_pkg::FMT_SOP1, salu_pkg::OPC_NOT_B32}:  r[31:0] = ~a;
            {salu_pkg::FMT_SOP1, salu_pkg::OPC_AND_SAVEEXEC_B64}: r = x & e;
            {salu_pkg::FMT_SOP1, salu_pkg::OPC_MOV_B32}: begin
                r[31:0] = a;
                we      = 1'b0;
            end
            {salu_pkg::FMT_SOP1, salu_pkg::OPC_MOV_B64}: begin
                r  = x;
                we = 1'b0;
            end
            {salu_pkg::FMT_SOP1, salu_pkg::OPC_BREV_B32}: begin
                for (i = 0; i < 32; i++) begin
                    r[i] = a[31 - i];
                end
                we = 1'b0;
            end
            {salu_pkg::FMT_SOP1, salu_pkg::OPC_SEXT_I32_I8}: begin
                r[31:0] = a[7] ? {24'hff_ffff, a[7:0]} : {24'h00_0000, a[7:0]};
                we      = 1'b0;
            end
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_EQ_I32},
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_EQ_U32}: f = a == b;
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LG_I32},
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LG_U32}: f = a != b;
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_GT_I32}: f = lt_signed(b, a);
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_GE_I32}: f = !lt_signed(a, b);
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LT_I32}: f = lt_signed(a, b);
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LE_I32}: f = !lt_signed(b, a);
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_GT_U32}: f = a > b;
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_GE_U32}: f = a >= b;
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LT_U32}: f = a < b;
            {salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LE_U32}: f = a <= b;
            default: begin
                bad = 1'b1;
                we  = 1'b0;
            end
        endcase
        // SOP1 ops and the SOP2 bitwise and shift opcodes set scc on a nonzero result
        if (!bad && (c[31:24] == salu_pkg::FMT_SOP1 ||
                     (c[31:24] == salu_pkg::FMT_SOP2 && c[23:0] >= salu_pkg::OPC_AND_B32))) begin
            f = r != '0;
        end
    endfunction

    task automatic compare_pending();
        if (pending) begin
            check($sformatf("out for control %h", exp_ctl), out, exp_out);
            check($sformatf("scc_we for control %h", exp_ctl),
                  salu_pkg::dword_t'(scc_we), salu_pkg::dword_t'(exp_we));
            check($sformatf("illegal for control %h", exp_ctl),
                  salu_pkg::dword_t'(illegal), salu_pkg::dword_t'(exp_ill));
            if (exp_we || exp_ill) begin
                check($sformatf("scc_val for control %h", exp_ctl),
                      salu_pkg::dword_t'(scc_val), salu_pkg::dword_t'(exp_scc));
            end
        end
    endtask

    // checks the previous op and applies the next one in the same cycle
    task automatic issue(input salu_pkg::control_t c, input salu_pkg::dword_t x,
                         input salu_pkg::dword_t y, input salu_pkg::dword_t e, input logic si);
        salu_pkg::dword_t r;
        logic             f;
        logic             w;
        logic             b;
        @(negedge clk);
        compare_pending();
        control = c;
        s1      = x;
        s2      = y;
        exec    = e;
        scc     = si;
        model(c, x, y, e, si, r, f, w, b);
        exp_ctl = c;
        exp_out = r;
        exp_scc = f;
        exp_we  = w;
        exp_ill = b;
        pending = 1'b1;
    endtask

    task automatic drain();
        @(negedge clk);
        compare_pending();
        pending = 1'b0;
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check("out in reset", out, 64'd0);
        check("scc_val in reset", salu_pkg::dword_t'(scc_val), 64'd0);
        check("scc_we in reset", salu_pkg::dword_t'(scc_we), 64'd0);
        check("illegal in reset", salu_pkg::dword_t'(illegal), 64'd0);
        rst = 1'b0;
    endtask

    task automatic test_arith();
        salu_pkg::control_t ops[9];
        salu_pkg::word_t    corner[5];
        ops = '{{salu_pkg::FMT_SOP2, salu_pkg::OPC_ADD_U32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_SUB_U32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_ADD_I32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_SUB_I32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_MIN_U32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_MAX_I32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_MAX_U32},
                {salu_pkg::FMT_SOPK, salu_pkg::OPC_MOVK_I32},
                {salu_pkg::FMT_SOPK, salu_pkg::OPC_ADDK_I32}};
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
        foreach (ops[k]) begin
            // random upper halves must not leak into the result
            foreach (corner[i]) begin
                foreach (corner[j]) begin
                    issue(ops[k], {rand_word(), corner[i]}, {rand_word(), corner[j]},
                          rand_dword(), 1'b0);
                end
            end
            repeat (n_rand) issue(ops[k], rand_dword(), rand_dword(), rand_dword(), 1'b0);
        end
    endtask

    task automatic test_logic();
        salu_pkg::control_t ops[10];
        ops = '{{salu_pkg::FMT_SOP2, salu_pkg::OPC_AND_B32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_OR_B32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_AND_B64},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_OR_B64},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_ANDN2_B64},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_LSHL_B32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_LSHR_B32},
                {salu_pkg::FMT_SOP2, salu_pkg::OPC_ASHR_I32},
                {salu_pkg::FMT_SOP1, salu_pkg::OPC_NOT_B32},
                {salu_pkg::FMT_SOP1, salu_pkg::OPC_MOV_B32}};
        foreach (ops[k]) begin
            repeat (n_rand) issue(ops[k], rand_dword(), rand_dword(), rand_dword(), 1'b0);
            // zero s1 gives a zero result for most of these
            issue(ops[k], 64'd0, rand_dword(), rand_dword(), 1'b0);
        end
    endtask

    task automatic test_unary();
        repeat (4) begin
            issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_BREV_B32}, rand_dword(), rand_dword(),
                  rand_dword(), 1'b0);
        end
        issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_SEXT_I32_I8}, {rand_word(), 24'habcdef, 8'h7f},
              rand_dword(), rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_SEXT_I32_I8}, {rand_word(), 24'h123456, 8'h80},
              rand_dword(), rand_dword(), 1'b0);
        repeat (2) begin
            issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_MOV_B64}, rand_dword(), rand_dword(),
                  rand_dword(), 1'b0);
        end
        issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_AND_SAVEEXEC_B64}, rand_dword(), rand_dword(),
              rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_AND_SAVEEXEC_B64}, rand_dword(), rand_dword(),
              64'd0, 1'b0);
        issue({salu_pkg::FMT_SOP2, salu_pkg::OPC_CSELECT_B32}, rand_dword(), rand_dword(),
              rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOP2, salu_pkg::OPC_CSELECT_B32}, rand_dword(), rand_dword(),
              rand_dword(), 1'b1);
    endtask

    task automatic test_compare();
        salu_pkg::word_t   lhs[6];
        salu_pkg::word_t   rhs[6];
        salu_pkg::opcode_t opc;
        // mixed signs where signed and unsigned order disagree
        lhs = '{32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h5, 32'hffff_ff00};
        rhs = '{32'hffff_ffff, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'h5, 32'hffff_ff00};
        for (opc = '0; opc <= salu_pkg::OPC_CMP_LE_U32; opc++) begin
            foreach (lhs[i]) begin
                issue({salu_pkg::FMT_SOPC, opc}, {rand_word(), lhs[i]}, {rand_word(), rhs[i]},
                      rand_dword(), 1'b0);
            end
        end
    endtask

    task automatic test_illegal();
        issue({8'h00, 24'h000000}, rand_dword(), rand_dword(), rand_dword(), 1'b1);
        issue({8'h01, 24'h000000}, rand_dword(), rand_dword(), rand_dword(), 1'b1);
        issue({8'h20, 24'h000003}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        issue({8'h0c, 24'h000000}, rand_dword(), rand_dword(), rand_dword(), 1'b1);
        issue({salu_pkg::FMT_SOP2, 24'h000004}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOP2, 24'h100000}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOPC, 24'h00000c}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOP1, 24'h000000}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOPK, 24'h000001}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        // different units on consecutive cycles
        issue({salu_pkg::FMT_SOP2, salu_pkg::OPC_ADD_U32}, 64'hffff_ffff, 64'h1,
              rand_dword(), 1'b0);
        issue({8'h40, 24'h000000}, rand_dword(), rand_dword(), rand_dword(), 1'b1);
        issue({salu_pkg::FMT_SOPC, salu_pkg::OPC_CMP_LT_I32}, 64'hffff_ffff, 64'h0,
              rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOP1, salu_pkg::OPC_AND_SAVEEXEC_B64}, rand_dword(), rand_dword(),
              rand_dword(), 1'b0);
        issue({8'h00, 24'h00000f}, rand_dword(), rand_dword(), rand_dword(), 1'b0);
        issue({salu_pkg::FMT_SOPK, salu_pkg::OPC_MOVK_I32}, rand_dword(), rand_dword(),
              rand_dword(), 1'b0);
    endtask

    initial begin
        seed    = 58;
        pending = 1'b0;
        rst     = 1'b1;
        s1      = '0;
        s2      = '0;
        exec    = '0;
        scc     = 1'b0;
        control = '0;
        test_reset();
        test_arith();
        test_logic();
        test_unary();
        test_compare();
        test_illegal();
        drain();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== testbench/scalar_alu_assertions.sv ====
module scalar_alu_assertions (
    input logic             clk,
    input logic             rst,
    input salu_pkg::dword_t out,
    input logic             scc_val,
    input logic             scc_we,
    input logic             illegal
);
    timeunit 1ns;
    timeprecision 1ps;

    // an unknown control word writes no scc
    illegal_no_scc: assert property (@(posedge clk) disable iff (rst)
        illegal |-> !scc_val && !scc_we)
        else $error("scc_val or scc_we high together with illegal");

    // and carries no data
    illegal_no_data: assert property (@(posedge clk) disable iff (rst)
        illegal |-> out == '0)
        else $error("nonzero out together with illegal");

    // registers cleared one cycle after reset
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> out == '0 && !scc_val && !scc_we && !illegal)
        else $error("outputs not cleared after reset");

endmodule

bind scalar_alu scalar_alu_assertions scalar_alu_assertions_i (
    .clk     (clk),
    .rst     (rst),
    .out     (out),
    .scc_val (scc_val),
    .scc_we  (scc_we),
    .illegal (illegal)
);

// ==== source/scalar_alu.sv ====
module scalar_alu (
    input  logic               clk,
    input  logic               rst,
    input  salu_pkg::dword_t   s1,
    input  salu_pkg::dword_t   s2,
    input  salu_pkg::dword_t   exec,
    input  logic               scc,
    input  salu_pkg::control_t control,
    output salu_pkg::dword_t   out,
    output logic               scc_val,
    output logic               scc_we,
    output logic               illegal
);

    salu_pkg::salu_op_e   op;
    salu_pkg::salu_unit_e unit;
    logic                 dec_scc_we;

    salu_pkg::dword_t arith_result;
    salu_pkg::dword_t logic_result;
    logic             arith_scc;
    logic             logic_scc;
    logic             cmp_scc;

    salu_pkg::dword_t nxt_out;
    logic             nxt_scc;

    salu_operand_if opnd ();

    assign opnd.s1   = s1;
    assign opnd.s2   = s2;
    assign opnd.exec = exec;
    assign opnd.scc  = scc;

    salu_decoder decoder_i (
        .control (control),
        .op      (op),
        .unit    (unit),
        .scc_we  (dec_scc_we)
    );

    salu_arith arith_i (
        .ops    (opnd.unit),
        .op     (op),
        .result (arith_result),
        .scc    (arith_scc)
    );

    salu_logic logic_i (
        .ops    (opnd.unit),
        .op     (op),
        .result (logic_result),
        .scc    (logic_scc)
    );

    salu_compare compare_i (
        .ops (opnd.unit),
        .op  (op),
        .scc (cmp_scc)
    );

    // pick the unit named by the decoder, compares carry no data
    always_comb begin
        case (unit)
            salu_pkg::UNIT_ARITH: begin
                nxt_out = arith_result;
                nxt_scc = arith_scc;
            end
            salu_pkg::UNIT_LOGIC: begin
                nxt_out = logic_result;
                nxt_scc = logic_scc;
            end
            salu_pkg::UNIT_COMPARE: begin
                nxt_out = '0;
                nxt_scc = cmp_scc;
            end
            default: begin
                nxt_out = '0;
                nxt_scc = 1'b0;
            end
        endcase
    end

    // one cycle of latency, new op every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            out     <= '0;
            scc_val <= 1'b0;
            scc_we  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            out     <= nxt_out;
            scc_val <= nxt_scc;
            scc_we  <= dec_scc_we;
            illegal <= unit == salu_pkg::UNIT_NONE;
        end
    end

endmodule

// ==== source/salu_compare.sv ====
module salu_compare (
    salu_operand_if.unit       ops,
    input  salu_pkg::salu_op_e op,
    output logic               scc
);

    salu_pkg::word_t    a;
    salu_pkg::word_t    b;
    logic signed [31:0] sa;
    logic signed [31:0] sb;

    assign a  = ops.s1[31:0];
    assign b  = ops.s2[31:0];

    // signed views of the same low words
    assign sa = a;
    assign sb = b;

    always_comb begin
        case (op)
            salu_pkg::OP_CMP_EQ_I32, salu_pkg::OP_CMP_EQ_U32: scc = a == b;
            salu_pkg::OP_CMP_LG_I32, salu_pkg::OP_CMP_LG_U32: scc = a != b;
            salu_pkg::OP_CMP_GT_I32: scc = sa > sb;
            salu_pkg::OP_CMP_GE_I32: scc = sa >= sb;
            salu_pkg::OP_CMP_LT_I32: scc = sa < sb;
            salu_pkg::OP_CMP_LE_I32: scc = sa <= sb;
            salu_pkg::OP_CMP_GT_U32: scc = a > b;
            salu_pkg::OP_CMP_GE_U32: scc = a >= b;
            salu_pkg::OP_CMP_LT_U32: scc = a < b;
            salu_pkg::OP_CMP_LE_U32: scc = a <= b;
            default:                 scc = 1'b0;
        endcase
    end

endmodule

// ==== source/salu_logic.sv ====
module salu_logic (
    salu_operand_if.unit       ops,
    input  salu_pkg::salu_op_e op,
    output salu_pkg::dword_t   result,
    output logic               scc
);

    salu_pkg::word_t a;
    salu_pkg::word_t b;
    salu_pkg::word_t rev;
    logic [4:0]      shamt;

    assign a     = ops.s1[31:0];
    assign b     = ops.s2[31:0];
    assign shamt = b[4:0];

    // bit 0 of s1 lands in bit 31
    assign rev = {<<{a}};

    always_comb begin
        result = '0;
        case (op)
            // unary on s1
            salu_pkg::OP_MOV_B32:     result = {32'd0, a};
            salu_pkg::OP_MOV_B64:     result = ops.s1;
            salu_pkg::OP_NOT_B32:     result = {32'd0, ~a};
            salu_pkg::OP_BREV_B32:    result = {32'd0, rev};
            salu_pkg::OP_SEXT_I32_I8: result = {32'd0, {24{a[7]}}, a[7:0]};

            // bitwise
            salu_pkg::OP_AND_B32:   result = {32'd0, a & b};
            salu_pkg::OP_OR_B32:    result = {32'd0, a | b};
            salu_pkg::OP_AND_B64:   result = ops.s1 & ops.s2;
            salu_pkg::OP_OR_B64:    result = ops.s1 | ops.s2;
            salu_pkg::OP_ANDN2_B64: result = ops.s1 & ~ops.s2;

            // shifts use the low five bits of s2
            salu_pkg::OP_LSHL_B32: result = {32'd0, a << shamt};
            salu_pkg::OP_LSHR_B32: result = {32'd0, a >> shamt};
            salu_pkg::OP_ASHR_I32: result = {32'd0, salu_pkg::word_t'($signed(a) >>> shamt)};

            salu_pkg::OP_AND_SAVEEXEC_B64: result = ops.s1 & ops.exec;
            default:                       result = '0;
        endcase
    end

    // upper half is already zero for 32-bit ops, so one test covers both widths
    assign scc = |result;

endmodule

// ==== source/salu_arith.sv ====
module salu_arith (
    salu_operand_if.unit       ops,
    input  salu_pkg::salu_op_e op,
    output salu_pkg::dword_t   result,
    output logic               scc
);

    salu_pkg::word_t a;
    salu_pkg::word_t b;
    salu_pkg::word_t lo;

    // full 33-bit sums, bit 32 is the carry out
    logic [32:0] add_full;
    logic [32:0] sub_full;

    // 31-bit sums, bit 31 is the carry into the sign bit
    logic [31:0] add_part;
    logic [31:0] sub_part;

    logic add_ovf;
    logic sub_ovf;

    assign a = ops.s1[31:0];
    assign b = ops.s2[31:0];

    // subtract as a + ~b + 1
    assign add_full = {1'b0, a} + {1'b0, b};
    assign sub_full = {1'b0, a} + {1'b0, ~b} + 33'd1;
    assign add_part = {1'b0, a[30:0]} + {1'b0, b[30:0]};
    assign sub_part = {1'b0, a[30:0]} + {1'b0, ~b[30:0]} + 32'd1;

    assign add_ovf = add_part[31] ^ add_full[32];
    assign sub_ovf = sub_part[31] ^ sub_full[32];

    always_comb begin
        lo  = '0;
        scc = 1'b0;
        case (op)
            salu_pkg::OP_ADD_U32: begin
                lo  = add_full[31:0];
                scc = add_full[32];
            end
            salu_pkg::OP_SUB_U32: begin
                lo  = sub_full[31:0];
                // borrow is the missing carry
                scc = ~sub_full[32];
            end
            salu_pkg::OP_ADD_I32, salu_pkg::OP_ADDK_I32: begin
                lo  = add_full[31:0];
                scc = add_ovf;
            end
            salu_pkg::OP_SUB_I32: begin
                lo  = sub_full[31:0];
                scc = sub_ovf;
            end
            salu_pkg::OP_MIN_U32: begin
                scc = a < b;
                lo  = scc ? a : b;
            end
            salu_pkg::OP_MAX_U32: begin
                scc = a > b;
                lo  = scc ? a : b;
            end
            salu_pkg::OP_MAX_I32: begin
                scc = $signed(a) > $signed(b);
                lo  = scc ? a : b;
            end
            salu_pkg::OP_MOVK_I32:    lo = b;
            salu_pkg::OP_CSELECT_B32: lo = ops.scc ? a : b;
            default:                  lo = '0;
        endcase
    end

    // 32-bit unit
    assign result = {32'd0, lo};

endmodule

// ==== source/salu_decoder.sv ====
module salu_decoder (
    input  salu_pkg::control_t   control,
    output salu_pkg::salu_op_e   op,
    output salu_pkg::salu_unit_e unit,
    output logic                 scc_we
);

    salu_pkg::format_t fmt;
    salu_pkg::opcode_t opc;

    assign fmt = control[31:24];
    assign opc = control[23:0];

    // format and opcode to operation
    always_comb begin
        op = salu_pkg::OP_NONE;
        case (fmt)
            salu_pkg::FMT_SOP2: begin
                case (opc)
                    salu_pkg::OPC_ADD_U32:     op = salu_pkg::OP_ADD_U32;
                    salu_pkg::OPC_SUB_U32:     op = salu_pkg::OP_SUB_U32;
                    salu_pkg::OPC_ADD_I32:     op = salu_pkg::OP_ADD_I32;
                    salu_pkg::OPC_SUB_I32:     op = salu_pkg::OP_SUB_I32;
                    salu_pkg::OPC_MIN_U32:     op = salu_pkg::OP_MIN_U32;
                    salu_pkg::OPC_MAX_I32:     op = salu_pkg::OP_MAX_I32;
                    salu_pkg::OPC_MAX_U32:     op = salu_pkg::OP_MAX_U32;
                    salu_pkg::OPC_CSELECT_B32: op = salu_pkg::OP_CSELECT_B32;
                    salu_pkg::OPC_AND_B32:     op = salu_pkg::OP_AND_B32;
                    salu_pkg::OPC_AND_B64:     op = salu_pkg::OP_AND_B64;
                    salu_pkg::OPC_OR_B32:      op = salu_pkg::OP_OR_B32;
                    salu_pkg::OPC_OR_B64:      op = salu_pkg::OP_OR_B64;
                    salu_pkg::OPC_ANDN2_B64:   op = salu_pkg::OP_ANDN2_B64;
                    salu_pkg::OPC_LSHL_B32:    op = salu_pkg::OP_LSHL_B32;
                    salu_pkg::OPC_LSHR_B32:    op = salu_pkg::OP_LSHR_B32;
                    salu_pkg::OPC_ASHR_I32:    op = salu_pkg::OP_ASHR_I32;
                    default:                   op = salu_pkg::OP_NONE;
                endcase
            end
            salu_pkg::FMT_SOPC: begin
                case (opc)
                    salu_pkg::OPC_CMP_EQ_I32: op = salu_pkg::OP_CMP_EQ_I32;
                    salu_pkg::OPC_CMP_LG_I32: op = salu_pkg::OP_CMP_LG_I32;
                    salu_pkg::OPC_CMP_GT_I32: op = salu_pkg::OP_CMP_GT_I32;
                    salu_pkg::OPC_CMP_GE_I32: op = salu_pkg::OP_CMP_GE_I32;
                    salu_pkg::OPC_CMP_LT_I32: op = salu_pkg::OP_CMP_LT_I32;
                    salu_pkg::OPC_CMP_LE_I32: op = salu_pkg::OP_CMP_LE_I32;
                    salu_pkg::OPC_CMP_EQ_U32: op = salu_pkg::OP_CMP_EQ_U32;
                    salu_pkg::OPC_CMP_LG_U32: op = salu_pkg::OP_CMP_LG_U32;
                    salu_pkg::OPC_CMP_GT_U32: op = salu_pkg::OP_CMP_GT_U32;
                    salu_pkg::OPC_CMP_GE_U32: op = salu_pkg::OP_CMP_GE_U32;
                    salu_pkg::OPC_CMP_LT_U32: op = salu_pkg::OP_CMP_LT_U32;
                    salu_pkg::OPC_CMP_LE_U32: op = salu_pkg::OP_CMP_LE_U32;
                    default:                  op = salu_pkg::OP_NONE;
                endcase
            end
            salu_pkg::FMT_SOP1: begin
                case (opc)
                    salu_pkg::OPC_MOV_B32:          op = salu_pkg::OP_MOV_B32;
                    salu_pkg::OPC_MOV_B64:          op = salu_pkg::OP_MOV_B64;
                    salu_pkg::OPC_NOT_B32:          op = salu_pkg::OP_NOT_B32;
                    salu_pkg::OPC_BREV_B32:         op = salu_pkg::OP_BREV_B32;
                    salu_pkg::OPC_SEXT_I32_I8:      op = salu_pkg::OP_SEXT_I32_I8;
                    salu_pkg::OPC_AND_SAVEEXEC_B64: op = salu_pkg::OP_AND_SAVEEXEC_B64;
                    default:                        op = salu_pkg::OP_NONE;
                endcase
            end
            salu_pkg::FMT_SOPK: begin
                case (opc)
                    salu_pkg::OPC_MOVK_I32: op = salu_pkg::OP_MOVK_I32;
                    salu_pkg::OPC_ADDK_I32: op = salu_pkg::OP_ADDK_I32;
                    default:                op = salu_pkg::OP_NONE;
                endcase
            end
            default: op = salu_pkg::OP_NONE;
        endcase
    end

    // operation to execution unit
    always_comb begin
        case (op)
            salu_pkg::OP_ADD_U32, salu_pkg::OP_SUB_U32, salu_pkg::OP_ADD_I32,
            salu_pkg::OP_SUB_I32, salu_pkg::OP_MIN_U32, salu_pkg::OP_MAX_I32,
            salu_pkg::OP_MAX_U32, salu_pkg::OP_CSELECT_B32, salu_pkg::OP_MOVK_I32,
            salu_pkg::OP_ADDK_I32:
                unit = salu_pkg::UNIT_ARITH;
            salu_pkg::OP_CMP_EQ_I32, salu_pkg::OP_CMP_LG_I32, salu_pkg::OP_CMP_GT_I32,
            salu_pkg::OP_CMP_GE_I32, salu_pkg::OP_CMP_LT_I32, salu_pkg::OP_CMP_LE_I32,
            salu_pkg::OP_CMP_EQ_U32, salu_pkg::OP_CMP_LG_U32, salu_pkg::OP_CMP_GT_U32,
            salu_pkg::OP_CMP_GE_U32, salu_pkg::OP_CMP_LT_U32, salu_pkg::OP_CMP_LE_U32:
                unit = salu_pkg::UNIT_COMPARE;
            salu_pkg::OP_NONE:
                unit = salu_pkg::UNIT_NONE;
            default:
                unit = salu_pkg::UNIT_LOGIC;
        endcase
    end

    // plain moves, brev, sext, movk and cselect leave scc alone
    always_comb begin
        case (op)
            salu_pkg::OP_NONE, salu_pkg::OP_MOVK_I32, salu_pkg::OP_CSELECT_B32,
            salu_pkg::OP_MOV_B32, salu_pkg::OP_MOV_B64, salu_pkg::OP_BREV_B32,
            salu_pkg::OP_SEXT_I32_I8:
                scc_we = 1'b0;
            default:
                scc_we = 1'b1;
        endcase
    end

endmodule

// ==== source/salu_operand_if.sv ====
interface salu_operand_if;

    // source registers and exec mask
    salu_pkg::dword_t s1;
    salu_pkg::dword_t s2;
    salu_pkg::dword_t exec;

    // scc as it stands before the operation
    logic scc;

    modport src (
        output s1, s2, exec, scc
    );

    // execution units only read operands
    modport unit (
        input s1, s2, exec, scc
    );

endinterface

// ==== source/salu_pkg.sv ====
package salu_pkg;

    // register widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [31:0] control_t;

    // control word fields
    typedef logic [7:0]  format_t;
    typedef logic [23:0] opcode_t;

    // one-hot instruction formats
    localparam format_t FMT_SOP1 = 8'h02;
    localparam format_t FMT_SOPC = 8'h04;
    localparam format_t FMT_SOP2 = 8'h08;
    localparam format_t FMT_SOPK = 8'h10;

    // SOP2 opcodes
    localparam opcode_t OPC_ADD_U32    = 24'h000000;
    localparam opcode_t OPC_SUB_U32    = 24'h000001;
    localparam opcode_t OPC_ADD_I32    = 24'h000002;
    localparam opcode_t OPC_SUB_I32    = 24'h000003;
    localparam opcode_t OPC_MIN_U32    = 24'h000007;
    localparam opcode_t OPC_MAX_I32    = 24'h000008;
    localparam opcode_t OPC_MAX_U32    = 24'h000009;
    localparam opcode_t OPC_CSELECT_B32 = 24'h00000a;
    localparam opcode_t OPC_AND_B32    = 24'h00000e;
    localparam opcode_t OPC_AND_B64    = 24'h00000f;
    localparam opcode_t OPC_OR_B32     = 24'h000010;
    localparam opcode_t OPC_OR_B64     = 24'h000011;
    localparam opcode_t OPC_ANDN2_B64  = 24'h000015;
    localparam opcode_t OPC_LSHL_B32   = 24'h00001e;
    localparam opcode_t OPC_LSHR_B32   = 24'h000020;
    localparam opcode_t OPC_ASHR_I32   = 24'h000022;

    // SOPC opcodes
    localparam opcode_t OPC_CMP_EQ_I32 = 24'h000000;
    localparam opcode_t OPC_CMP_LG_I32 = 24'h000001;
    localparam opcode_t OPC_CMP_GT_I32 = 24'h000002;
    localparam opcode_t OPC_CMP_GE_I32 = 24'h000003;
    localparam opcode_t OPC_CMP_LT_I32 = 24'h000004;
    localparam opcode_t OPC_CMP_LE_I32 = 24'h000005;
    localparam opcode_t OPC_CMP_EQ_U32 = 24'h000006;
    localparam opcode_t OPC_CMP_LG_U32 = 24'h000007;
    localparam opcode_t OPC_CMP_GT_U32 = 24'h000008;
    localparam opcode_t OPC_CMP_GE_U32 = 24'h000009;
    localparam opcode_t OPC_CMP_LT_U32 = 24'h00000a;
    localparam opcode_t OPC_CMP_LE_U32 = 24'h00000b;

    // SOP1 opcodes
    localparam opcode_t OPC_MOV_B32         = 24'h000003;
    localparam opcode_t OPC_MOV_B64         = 24'h000004;
    localparam opcode_t OPC_NOT_B32         = 24'h000007;
    localparam opcode_t OPC_BREV_B32        = 24'h00000b;
    localparam opcode_t OPC_SEXT_I32_I8     = 24'h000019;
    localparam opcode_t OPC_AND_SAVEEXEC_B64 = 24'h000024;

    // SOPK opcodes
    localparam opcode_t OPC_MOVK_I32 = 24'h000000;
    localparam opcode_t OPC_ADDK_I32 = 24'h00000f;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD_U32, OP_SUB_U32, OP_ADD_I32, OP_SUB_I32,
        OP_MIN_U32, OP_MAX_I32, OP_MAX_U32, OP_CSELECT_B32,
        OP_AND_B32, OP_AND_B64, OP_OR_B32, OP_OR_B64, OP_ANDN2_B64,
        OP_LSHL_B32, OP_LSHR_B32, OP_ASHR_I32,
        OP_CMP_EQ_I32, OP_CMP_LG_I32, OP_CMP_GT_I32,
        OP_CMP_GE_I32, OP_CMP_LT_I32, OP_CMP_LE_I32,
        OP_CMP_EQ_U32, OP_CMP_LG_U32, OP_CMP_GT_U32,
        OP_CMP_GE_U32, OP_CMP_LT_U32, OP_CMP_LE_U32,
        OP_MOV_B32, OP_MOV_B64, OP_NOT_B32, OP_BREV_B32,
        OP_SEXT_I32_I8, OP_AND_SAVEEXEC_B64,
        OP_MOVK_I32, OP_ADDK_I32
    } salu_op_e;

    typedef enum logic [1:0] {
        UNIT_ARITH,
        UNIT_LOGIC,
        UNIT_COMPARE,
        UNIT_NONE
    } salu_unit_e;

endpackage
